// File: rtl/sprite_pkg.sv
/* Sprite display package
   Coordinate, colour, register and video bus types shared by the pipeline */

package sprite_pkg;

    localparam int CORDW = 16;               // Coordinate width

    typedef logic [CORDW-1:0] cord_t;        // Unsigned raster coordinate

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Video bus from paint stage into the TMDS encoders
    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
        rgb_t rgb;
    } vid_t;

    typedef struct packed {
        cord_t x;
        cord_t y;
    } sprite_pos_t;

    // Colour view of a register write word
    typedef struct packed {
        logic [7:0] pad;                     // Ignored
        rgb_t       rgb;
    } reg_col_t;

    // One write word, two decodes; address picks the view
    typedef union packed {
        sprite_pos_t pos;
        reg_col_t    col;
    } reg_data_u;

    typedef logic [1:0] reg_addr_t;

    localparam reg_addr_t REG_POS = 2'd0;    // Sprite position, loaded at frame start
    localparam reg_addr_t REG_FG  = 2'd1;    // Foreground colour
    localparam reg_addr_t REG_BG  = 2'd2;    // Background colour

    typedef logic [9:0] tmds_sym_t;

    // DVI control symbols, indexed by {c1, c0}
    localparam tmds_sym_t TMDS_CTRL_00 = 10'b1101010100;
    localparam tmds_sym_t TMDS_CTRL_01 = 10'b0010101011;
    localparam tmds_sym_t TMDS_CTRL_10 = 10'b0101010100;
    localparam tmds_sym_t TMDS_CTRL_11 = 10'b1010101011;

    localparam rgb_t FG_RESET = '{r: 8'hFF, g: 8'hCC, b: 8'h00};         // Yellow
    localparam rgb_t BG_RESET = '{r: 8'h11, g: 8'h33, b: 8'h77};         // Blue
    localparam sprite_pos_t POS_RESET = '{x: 16'd4, y: 16'd2};

endpackage

// File: rtl/display_timing.sv
/* Display timing generator
   Raster counters with registered sync, data enable, line and frame strobes */

`timescale 1ns/1ps

module display_timing #(
    parameter int H_RES  = 640,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_RES  = 480,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic              clk_pix,
    input  logic              rst,
    output sprite_pkg::cord_t sx,
    output sprite_pkg::cord_t sy,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic              line,
    output logic              frame
);
    import sprite_pkg::*;

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    localparam cord_t H_LAST = cord_t'(H_TOTAL - 1);         // Last column of the line
    localparam cord_t V_LAST = cord_t'(V_TOTAL - 1);         // Last line of the frame
    localparam cord_t H_ACT  = cord_t'(H_RES);
    localparam cord_t V_ACT  = cord_t'(V_RES);
    localparam cord_t HS_STA = cord_t'(H_RES + H_FP);
    localparam cord_t HS_END = cord_t'(H_RES + H_FP + H_SYNC);
    localparam cord_t VS_STA = cord_t'(V_RES + V_FP);
    localparam cord_t VS_END = cord_t'(V_RES + V_FP + V_SYNC);

    cord_t sx_n, sy_n;                                        // Position of the next pixel

    // Wrap compares
    always_comb begin
        sx_n = sx + 1'b1;
        sy_n = sy;
        if (sx == H_LAST) begin
            sx_n = '0;
            sy_n = (sy == V_LAST) ? '0 : sy + 1'b1;
        end
    end

    // Flags are registered from the next position so they line up with sx and sy
    // Reset parks on the last pixel of the frame, so the first clock after
    // reset shows sx 0, sy 0 together with a frame strobe
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= H_LAST;
            sy    <= V_LAST;
            hsync <= 1'b0;                                    // Back porch, sync inactive
            vsync <= 1'b0;
            de    <= 1'b0;
            line  <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_n;
            sy    <= sy_n;
            hsync <= (sx_n >= HS_STA) && (sx_n < HS_END);     // Active high
            vsync <= (sy_n >= VS_STA) && (sy_n < VS_END);
            de    <= (sx_n < H_ACT) && (sy_n < V_ACT);
            line  <= (sx_n == '0);
            frame <= (sx_n == '0) && (sy_n == '0);
        end
    end

endmodule

// File: rtl/sprite_regs.sv
/* Sprite register block
   Colour registers plus a position that is taken over only at frame start */

`timescale 1ns/1ps

module sprite_regs (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    reg_we,     // One-cycle write strobe
    input  sprite_pkg::reg_addr_t   reg_addr,
    input  sprite_pkg::reg_data_u   reg_wdata,
    input  logic                    frame,      // First pixel of the frame
    output sprite_pkg::sprite_pos_t pos,
    output sprite_pkg::rgb_t        fg,
    output sprite_pkg::rgb_t        bg
);
    import sprite_pkg::*;

    sprite_pos_t pos_pend;                      // Last written position
    sprite_pos_t pos_act;                       // Position of the frame being drawn

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            pos_pend <= POS_RESET;
            pos_act  <= POS_RESET;
            fg       <= FG_RESET;
            bg       <= BG_RESET;
        end else begin
            if (reg_we) begin
                case (reg_addr)
                    REG_POS: pos_pend <= reg_wdata.pos;       // Position view
                    REG_FG:  fg       <= reg_wdata.col.rgb;   // Colour view, pad dropped
                    REG_BG:  bg       <= reg_wdata.col.rgb;
                    default: ;                                // Unused address
                endcase
            end
            if (frame) begin
                pos_act <= pos_pend;            // Swap only between frames, no tearing
            end
        end
    end

    // The sprite decides on the frame pixel itself, so hand it the
    // pending copy during that one cycle
    assign pos = frame ? pos_pend : pos_act;

endmodule

// File: rtl/sprite_inline.sv
/* Inline sprite renderer
   Draws a fixed 8x8 "F" bitmap at pos, scaled by pixel and line replication */

`timescale 1ns/1ps

module sprite_inline #(
    parameter int SPR_SCALE = 1                 // 1, 2 or 4
) (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    line,       // Start of line
    input  sprite_pkg::cord_t       sx,
    input  sprite_pkg::cord_t       sy,
    input  sprite_pkg::sprite_pos_t pos,
    output logic                    pix,        // Bitmap bit under the pixel
    output logic                    drawing     // Pixel is inside the sprite
);
    import sprite_pkg::*;

    localparam logic [1:0] SCALE_LAST = 2'(SPR_SCALE - 1);

    typedef enum logic [2:0] {
        IDLE,                                   // No sprite row in progress
        WAIT_LINE,                              // Between sprite rows
        WAIT_X,                                 // Row armed, hunting for pos.x
        DRAW,
        LINE_DONE                               // Row finished
    } state_t;

    state_t     state, state_n;
    logic [2:0] row, row_n;                     // Bitmap row
    logic [1:0] rcnt, rcnt_n;                   // Line replication count
    logic [2:0] col, col_n, col_now;            // Bitmap column
    logic [1:0] ccnt, ccnt_n, ccnt_now;         // Pixel replication count
    logic       row_last;
    logic       hunt;                           // Compare sx with pos.x this cycle
    logic       draw_now;                       // Current pixel is drawn
    logic [7:0] bits;

    // Bitmap, leftmost pixel in bit 7
    function automatic logic [7:0] bitmap_row(input logic [2:0] r);
        case (r)
            3'd0:    return 8'b1111_1110;
            3'd1:    return 8'b1100_0000;
            3'd2:    return 8'b1100_0000;
            3'd3:    return 8'b1111_1100;
            3'd4:    return 8'b1100_0000;
            3'd5:    return 8'b1100_0000;
            3'd6:    return 8'b1100_0000;
            default: return 8'b0000_0000;
        endcase
    endfunction

    assign row_last = (row == 3'd7) && (rcnt == SCALE_LAST);   // Last line of the sprite

    always_comb begin
        state_n  = state;
        row_n    = row;
        rcnt_n   = rcnt;
        col_n    = col;
        ccnt_n   = ccnt;
        col_now  = col;
        ccnt_now = ccnt;
        hunt     = 1'b0;
        draw_now = 1'b0;

        if (line) begin
            // Line start wins over any state, cuts off rows running past the line end
            if (sy == pos.y) begin
                row_n  = '0;                    // First sprite line
                rcnt_n = '0;
                hunt   = 1'b1;
            end else if (state != IDLE && !row_last && sy != '0) begin
                if (rcnt == SCALE_LAST) begin
                    row_n  = row + 3'd1;
                    rcnt_n = '0;
                end else begin
                    rcnt_n = rcnt + 2'd1;       // Repeat the row
                end
                hunt = 1'b1;
            end else begin
                state_n = IDLE;                 // Sprite done or clipped at frame end
            end
        end else begin
            case (state)
                WAIT_X:    hunt     = 1'b1;
                DRAW:      draw_now = 1'b1;
                LINE_DONE: state_n  = row_last ? IDLE : WAIT_LINE;
                default:   ;
            endcase
        end

        if (hunt) begin
            if (sx == pos.x) begin
                draw_now = 1'b1;                // Left edge, drawn this pixel
                col_now  = '0;
                ccnt_now = '0;
            end else begin
                state_n = WAIT_X;
            end
        end

        if (draw_now) begin
            state_n = DRAW;
            if (ccnt_now == SCALE_LAST) begin
                ccnt_n = '0;
                col_n  = col_now + 3'd1;
                if (col_now == 3'd7) begin
                    state_n = LINE_DONE;        // Right edge reached
                end
            end else begin
                ccnt_n = ccnt_now + 2'd1;
                col_n  = col_now;
            end
        end
    end

    assign bits = bitmap_row(row_n);            // New row applies from the line pixel

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state   <= IDLE;
            row     <= '0;
            rcnt    <= '0;
            col     <= '0;
            ccnt    <= '0;
            drawing <= 1'b0;
            pix     <= 1'b0;
        end else begin
            state   <= state_n;
            row     <= row_n;
            rcnt    <= rcnt_n;
            col     <= col_n;
            ccnt    <= ccnt_n;
            drawing <= draw_now;                // One cycle behind sx
            pix     <= draw_now && bits[3'd7 - col_now];
        end
    end

endmodule

// File: rtl/tmds_encoder.sv
/* DVI TMDS encoder
   8b/10b transition minimised symbols with running disparity, control in blanking */

`timescale 1ns/1ps

module tmds_encoder (
    input  logic                  clk_pix,
    input  logic                  rst,
    input  logic                  de,
    input  logic [7:0]            data,
    input  logic [1:0]            ctrl,     // {c1, c0}
    output sprite_pkg::tmds_sym_t sym
);
    import sprite_pkg::*;

    logic [3:0]        ones_d;              // Ones in the input byte
    logic              use_xnor;
    logic [8:0]        q_m;                 // Transition minimised word
    logic [3:0]        ones_q;              // Ones in q_m[7:0]
    logic signed [5:0] bal;                 // Ones minus zeros of q_m[7:0]
    logic signed [5:0] cnt, cnt_n;          // Running disparity
    tmds_sym_t         ctrl_sym, sym_n;

    // XOR or XNOR chain, bit 8 flags XOR
    function automatic logic [8:0] minimise(input logic [7:0] d, input logic xn);
        logic [8:0] q;
        q[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = xn ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
        end
        q[8] = ~xn;
        return q;
    endfunction

    always_comb begin
        ones_d   = 4'($countones(data));
        use_xnor = (ones_d > 4'd4) || (ones_d == 4'd4 && !data[0]);
        q_m      = minimise(data, use_xnor);
        ones_q   = 4'($countones(q_m[7:0]));
        bal      = 6'(2 * ones_q) - 6'sd8;
    end

    always_comb begin
        case (ctrl)
            2'b00:   ctrl_sym = TMDS_CTRL_00;
            2'b01:   ctrl_sym = TMDS_CTRL_01;
            2'b10:   ctrl_sym = TMDS_CTRL_10;
            default: ctrl_sym = TMDS_CTRL_11;
        endcase
    end

    always_comb begin
        sym_n = ctrl_sym;                   // Blanking
        cnt_n = '0;                         // Disparity restarts each active period
        if (de) begin
            if (cnt == '0 || ones_q == 4'd4) begin
                // Balanced, bit 9 tells the decoder whether to invert
                sym_n = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
                cnt_n = q_m[8] ? cnt + bal : cnt - bal;
            end else if ((!cnt[5] && ones_q > 4'd4) || (cnt[5] && ones_q < 4'd4)) begin
                sym_n = {1'b1, q_m[8], ~q_m[7:0]};       // Invert to pull back to zero
                cnt_n = cnt + 6'({q_m[8], 1'b0}) - bal;
            end else begin
                sym_n = {1'b0, q_m[8], q_m[7:0]};
                cnt_n = cnt - 6'({~q_m[8], 1'b0}) + bal;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sym <= TMDS_CTRL_00;
            cnt <= '0;
        end else begin
            sym <= sym_n;
            cnt <= cnt_n;
        end
    end

endmodule

// File: rtl/sprite_display_top.sv
/* Sprite display top level
   Timing, registers, inline sprite, paint and blank stage, three TMDS channels */

`timescale 1ns/1ps

module sprite_display_top #(
    parameter int H_RES     = 640,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_RES     = 480,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33,
    parameter int SPR_SCALE = 4
) (
    input  logic                  clk_pix,
    input  logic                  rst,
    input  logic                  reg_we,
    input  sprite_pkg::reg_addr_t reg_addr,
    input  sprite_pkg::reg_data_u reg_wdata,
    output sprite_pkg::tmds_sym_t tmds_ch0,     // Blue and sync
    output sprite_pkg::tmds_sym_t tmds_ch1,     // Green
    output sprite_pkg::tmds_sym_t tmds_ch2      // Red
);
    import sprite_pkg::*;

    cord_t       sx, sy;
    logic        hsync, vsync, de, line, frame;
    sprite_pos_t pos;
    rgb_t        fg, bg;
    logic        pix, drawing;
    logic        de_d, hsync_d, vsync_d;        // Sync delayed to match pix
    vid_t        vid;

    display_timing #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing0 (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .line, .frame
    );

    sprite_regs regs0 (
        .clk_pix, .rst, .reg_we, .reg_addr, .reg_wdata, .frame, .pos, .fg, .bg
    );

    sprite_inline #(.SPR_SCALE(SPR_SCALE)) sprite0 (
        .clk_pix, .rst, .line, .sx, .sy, .pos, .pix, .drawing
    );

    // Align, then paint and blank
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            de_d    <= 1'b0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            vid     <= '0;
        end else begin
            de_d      <= de;
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            vid.de    <= de_d;
            vid.hsync <= hsync_d;
            vid.vsync <= vsync_d;
            if (!de_d) vid.rgb <= '0;                     // Black in blanking
            else       vid.rgb <= (drawing && pix) ? fg : bg;
        end
    end

    tmds_encoder enc_ch0 (
        .clk_pix, .rst, .de(vid.de), .data(vid.rgb.b),
        .ctrl({vid.vsync, vid.hsync}), .sym(tmds_ch0)
    );

    tmds_encoder enc_ch1 (
        .clk_pix, .rst, .de(vid.de), .data(vid.rgb.g), .ctrl(2'b00), .sym(tmds_ch1)
    );

    tmds_encoder enc_ch2 (
        .clk_pix, .rst, .de(vid.de), .data(vid.rgb.r), .ctrl(2'b00), .sym(tmds_ch2)
    );

endmodule

// File: verif/sprite_display_assertions.sv
/* Sprite display assertions
   Blanking control symbols and per-line disparity on the three TMDS channels */

`timescale 1ns/1ps

module sprite_display_assertions (
    input logic                  clk_pix,
    input logic                  rst,
    input sprite_pkg::vid_t      vid,          // Encoder input bus
    input sprite_pkg::tmds_sym_t tmds_ch0,
    input sprite_pkg::tmds_sym_t tmds_ch1,
    input sprite_pkg::tmds_sym_t tmds_ch2
);
    import sprite_pkg::*;

    tmds_sym_t         syms [3];
    logic signed [7:0] disp [3];                // Disparity of the line so far
    logic              prev_data [3];           // Last symbol carried data

    function automatic logic is_ctrl(input tmds_sym_t s);
        return s == TMDS_CTRL_00 || s == TMDS_CTRL_01 || s == TMDS_CTRL_10 ||
               s == TMDS_CTRL_11;
    endfunction

    function automatic logic signed [7:0] sym_disp(input tmds_sym_t s);
        return 8'(2 * $countones(s)) - 8'sd10;  // Ones minus zeros
    endfunction

    function automatic logic in_band(input logic signed [7:0] d);
        return d <= 8'sd10 && d >= -8'sd10;
    endfunction

    assign syms[0] = tmds_ch0;
    assign syms[1] = tmds_ch1;
    assign syms[2] = tmds_ch2;

    always_ff @(posedge clk_pix) begin
        for (int c = 0; c < 3; c++) begin
            if (rst || is_ctrl(syms[c])) disp[c] <= '0;   // Restart each line
            else disp[c] <= disp[c] + sym_disp(syms[c]);
            prev_data[c] <= !rst && !is_ctrl(syms[c]);
        end
    end

    a_blank_ctrl: assert property (@(posedge clk_pix) disable iff (rst)
        !vid.de |=> is_ctrl(tmds_ch0) && is_ctrl(tmds_ch1) && is_ctrl(tmds_ch2))
        else $error("Blanking symbol is not a control code");

    a_ch12_ctrl00: assert property (@(posedge clk_pix) disable iff (rst)
        !vid.de |=> tmds_ch1 == TMDS_CTRL_00 && tmds_ch2 == TMDS_CTRL_00)
        else $error("ch1 or ch2 control bits not 00 in blanking");

    // Checked where the active line ends
    a_disp_ch0: assert property (@(posedge clk_pix) disable iff (rst)
        prev_data[0] && is_ctrl(tmds_ch0) |-> in_band(disp[0]))
        else $error("ch0 line disparity out of range");
    a_disp_ch1: assert property (@(posedge clk_pix) disable iff (rst)
        prev_data[1] && is_ctrl(tmds_ch1) |-> in_band(disp[1]))
        else $error("ch1 line disparity out of range");
    a_disp_ch2: assert property (@(posedge clk_pix) disable iff (rst)
        prev_data[2] && is_ctrl(tmds_ch2) |-> in_band(disp[2]))
        else $error("ch2 line disparity out of range");

endmodule

// File: verif/tb_sprite_display.sv
/* Sprite display testbench
   Tiny raster, reference model of timing, sprite and registers, TMDS decode checks */

`timescale 1ns/1ps

module tb_sprite_display;
    import sprite_pkg::*;

    localparam int H_RES = 32, H_FP = 2, H_SYNC = 4, H_BP = 2;
    localparam int V_RES = 16, V_FP = 1, V_SYNC = 2, V_BP = 1;
    localparam int SCALE     = 2;
    localparam int H_TOT     = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOT     = V_RES + V_FP + V_SYNC + V_BP;
    localparam int FRAME_LEN = H_TOT * V_TOT;               // Cycles per frame
    localparam int N_FRAMES  = 24;                          // Frames over all tests, with slack
    localparam int TIMEOUT   = N_FRAMES * FRAME_LEN * 4 + 2000;   // ns
    localparam logic [31:0] SEED = 32'h421a_d2b2;

    // Letter F, leftmost pixel first
    localparam string FONT [8] = '{"XXXXXXX.", "XX......", "XX......", "XXXXXX..",
                                  "XX......", "XX......", "XX......", "........"};

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
        logic fgpix;                                        // Sprite bit set here
    } pix_rec_t;

    logic       clk_pix, rst, reg_we;
    reg_addr_t  reg_addr;
    reg_data_u  reg_wdata;
    tmds_sym_t  tmds_ch0, tmds_ch1, tmds_ch2;

    int          mx, my;                                    // Model raster position
    sprite_pos_t m_pend, m_act;
    rgb_t        m_fg, m_bg;
    pix_rec_t    p1, p2;                                    // Sprite and align stages
    vid_t        vid_m, exp_vid;                            // Paint stage, encoder output
    logic        chk_on;
    int          errors, err_mark, tests_ok, tests_bad, sprite_hits;
    int          fg_seen;                                   // DUT pixels decoding to FG_RESET

    sprite_display_top #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP), .SPR_SCALE(SCALE)
    ) dut0 (
        .clk_pix, .rst, .reg_we, .reg_addr, .reg_wdata, .tmds_ch0, .tmds_ch1, .tmds_ch2
    );

    bind sprite_display_top sprite_display_assertions asrt0 (.*);

    always #2 clk_pix = ~clk_pix;

    function automatic pix_rec_t model_pixel(input int x, input int y, input sprite_pos_t p);
        pix_rec_t r;
        int       px, py;
        px      = int'(p.x);
        py      = int'(p.y);
        r.de    = (x < H_RES) && (y < V_RES);
        r.hs    = (x >= H_RES + H_FP) && (x < H_RES + H_FP + H_SYNC);
        r.vs    = (y >= V_RES + V_FP) && (y < V_RES + V_FP + V_SYNC);
        r.fgpix = 1'b0;
        if (x >= px && x < px + 8 * SCALE && y >= py && y < py + 8 * SCALE)
            r.fgpix = (FONT[(y - py) / SCALE][(x - px) / SCALE] == "X");
        return r;
    endfunction

    function automatic vid_t paint(input pix_rec_t r);
        vid_t v;
        v.de    = r.de;
        v.hsync = r.hs;
        v.vsync = r.vs;
        v.rgb   = !r.de ? '0 : (r.fgpix ? m_fg : m_bg);
        return v;
    endfunction

    // {is_ctrl, ctrl, data}, undoes inversion then the XOR or XNOR chain
    function automatic logic [10:0] decode_sym(input tmds_sym_t s);
        logic [7:0] q, d;
        case (s)
            10'b1101010100: return {1'b1, 2'b00, 8'h00};
            10'b0010101011: return {1'b1, 2'b01, 8'h00};
            10'b0101010100: return {1'b1, 2'b10, 8'h00};
            10'b1010101011: return {1'b1, 2'b11, 8'h00};
            default: ;
        endcase
        q    = s[9] ? ~s[7:0] : s[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++)
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        return {1'b0, 2'b00, d};
    endfunction

    // All three channels carry data that decodes to colour c
    function automatic logic shows_colour(input tmds_sym_t s0, input tmds_sym_t s1,
                                          input tmds_sym_t s2, input rgb_t c);
        logic [10:0] d0, d1, d2;
        d0 = decode_sym(s0);
        d1 = decode_sym(s1);
        d2 = decode_sym(s2);
        return !d0[10] && !d1[10] && !d2[10] &&
               d0[7:0] == c.b && d1[7:0] == c.g && d2[7:0] == c.r;
    endfunction

    task automatic check_channel(input string name, input tmds_sym_t s, input logic de,
                                 input logic [7:0] data, input logic [1:0] ctrl);
        logic [10:0] dec;
        dec = decode_sym(s);
        assert (dec[10] == !de) else begin
            errors++;
            $display("[ERROR] %s de expected %h got %h (sym %h)", name, de, !dec[10], s);
        end
        if (de) begin
            assert (dec[7:0] == data) else begin
                errors++;
                $display("[ERROR] %s data expected %h got %h at %0d,%0d", name, data,
                         dec[7:0], mx, my);
            end
        end else begin
            assert (dec[9:8] == ctrl) else begin
                errors++;
                $display("[ERROR] %s ctrl expected %h got %h", name, ctrl, dec[9:8]);
            end
        end
    endtask

    // Model steps in DUT order, colours read before this edge's write
    always @(posedge clk_pix) begin
        if (rst) begin
            mx = H_TOT - 1;                                 // First step lands on 0,0
            my = V_TOT - 1;
            m_pend  = POS_RESET;
            m_act   = POS_RESET;
            m_fg    = FG_RESET;
            m_bg    = BG_RESET;
            p1      = '0;
            p2      = '0;
            vid_m   = '0;
            exp_vid = '0;
            chk_on  = 1'b0;
        end else begin
            exp_vid = vid_m;                                // Encoders register one later
            vid_m   = paint(p2);
            if (p2.de && p2.fgpix) sprite_hits++;
            p2 = p1;
            if (reg_we) begin
                if (reg_addr == REG_POS) m_pend = reg_wdata.pos;
                if (reg_addr == REG_FG)  m_fg   = reg_wdata.col.rgb;
                if (reg_addr == REG_BG)  m_bg   = reg_wdata.col.rgb;
            end
            mx = (mx == H_TOT - 1) ? 0 : mx + 1;
            if (mx == 0) my = (my == V_TOT - 1) ? 0 : my + 1;
            if (mx == 0 && my == 0) m_act = m_pend;         // New position at frame start
            p1     = model_pixel(mx, my, m_act);
            chk_on = 1'b1;
        end
    end

    always @(negedge clk_pix) begin
        if (chk_on && !rst) begin
            check_channel("tmds_ch0", tmds_ch0, exp_vid.de, exp_vid.rgb.b,
                          {exp_vid.vsync, exp_vid.hsync});
            check_channel("tmds_ch1", tmds_ch1, exp_vid.de, exp_vid.rgb.g, 2'b00);
            check_channel("tmds_ch2", tmds_ch2, exp_vid.de, exp_vid.rgb.r, 2'b00);
            if (shows_colour(tmds_ch0, tmds_ch1, tmds_ch2, FG_RESET)) fg_seen++;
        end
    end

    task automatic write_reg(input reg_addr_t a, input reg_data_u d);
        @(negedge clk_pix);
        reg_we    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge clk_pix);
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
    endtask

    task automatic wait_at(input int x, input int y);
        do @(negedge clk_pix); while (!(mx == x && my == y));
    endtask

    task automatic wait_frames(input int n);
        repeat (n) wait_at(0, 0);
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) tests_ok++;
        else tests_bad++;
        $display("test %-14s %s (%0d errors)", name, (errors == err_mark) ? "ok" : "FAILED",
                 errors - err_mark);
        err_mark = errors;
    endtask

    task automatic move_sprite(input int x, input int y);
        reg_data_u w;
        w.pos.x = cord_t'(x);
        w.pos.y = cord_t'(y);
        wait_at(3, V_RES / 2);                              // Mid-frame write
        write_reg(REG_POS, w);
        write_reg(2'd3, reg_data_u'(32'hDEAD_BEEF));        // Unused address, ignored
        wait_frames(2);
    endtask

    initial begin
        automatic reg_data_u w;
        automatic logic [31:0] r;
        clk_pix = 1'b0;
        rst = 1'b1;
        reg_we = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        errors = 0;
        err_mark = 0;
        tests_ok = 0;
        tests_bad = 0;
        sprite_hits = 0;
        fg_seen = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk_pix);
        @(negedge clk_pix);
        rst = 1'b0;

        wait_frames(1);
        finish_test("sync_blank");
        wait_frames(1);
        finish_test("background");
        sprite_hits = 0;
        fg_seen = 0;
        wait_frames(1);
        assert (fg_seen == sprite_hits) else begin
            errors++;
            $display("[ERROR] fg_pixels expected %h got %h", sprite_hits, fg_seen);
        end
        finish_test("sprite_shape");

        for (int i = 0; i < 6; i++) begin
            r = $urandom;
            w.col.pad = 8'hA5;
            w.col.rgb = rgb_t'(r[23:0]);
            repeat ($urandom_range(20, 200)) @(negedge clk_pix);
            write_reg(i[0] ? REG_FG : REG_BG, w);           // Both colours get written
        end
        wait_frames(1);
        finish_test("colour_writes");

        repeat (3) move_sprite($urandom_range(0, H_RES - 1), $urandom_range(0, V_RES - 1));
        move_sprite(H_RES - 3, 1);                          // Clipped at the right
        move_sprite(5, V_RES - 5);                          // Clipped at the bottom
        move_sprite(0, 0);
        finish_test("position");

        $display("tests passed %0d failed %0d, %0d errors", tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: filelist.f
rtl/sprite_pkg.sv
rtl/display_timing.sv
rtl/sprite_regs.sv
rtl/sprite_inline.sv
rtl/tmds_encoder.sv
rtl/sprite_display_top.sv
verif/sprite_display_assertions.sv
verif/tb_sprite_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sprite display simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_sprite_display -o sim_sprite_display

./obj_dir/sim_sprite_display | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
